// File: files.f
+incdir+sim
rtl/rvIsaPkg.sv
rtl/ctrlPkg.sv
rtl/mainDecoder.sv
rtl/aluDecoder.sv
rtl/executeCtrl.sv
rtl/memWbCtrl.sv
rtl/controller.sv
sim/clockGen.sv
sim/controllerTb.sv

// File: rtl/aluDecoder.sv
/* ALU, CSR and fence decode */
`timescale 1ns/100ps

module aluDecoder import rvIsaPkg::*, ctrlPkg::*; (
  input  opcodeT     opD,               // Bit 5 tells reg from imm form
  input  funct3T     funct3D,
  input  funct7T     funct7D,
  input  regAdrT     rs1D,              // rs1 or CSR uimm
  input  logic       aluOpD,
  input  logic       csrReadD,
  input  logic       privilegedD,
  input  logic       fenceXD,
  output aluControlT aluControlD,       // {subArith, aluOp}
  output logic       csrWriteD,         // CSR gets updated
  output logic       fenceD,            // fence, fence.i or sfence.vma
  output logic       invalidateICacheD,
  output logic       flushDCacheD
);

  logic subD, sraD, sltD, sltuD; // Ops needing inverted operand B
  logic subArithD;
  logic csrZeroSrcD;             // Source register or uimm is zero
  logic fenceID;
  logic sfenceVmaD;

  //////////////////////////////
  // ALU control
  //////////////////////////////

  // Only funct7 bit 5 is looked at for sub and sra
  assign subD  = (funct3D == f3AddSub) & funct7D[5] & opD[5]; // addi has no sub
  assign sraD  = (funct3D == f3Shr) & funct7D[5];
  assign sltD  = (funct3D == f3Slt);
  assign sltuD = (funct3D == f3Sltu);

  assign subArithD   = aluOpD & (subD | sraD | sltD | sltuD);
  assign aluControlD = {subArithD, aluOpD};

  //////////////////////////////
  // CSR and fences
  //////////////////////////////

  // rs1 and uimm share instr[19:15]
  assign csrZeroSrcD = (rs1D == '0);
  assign csrWriteD   = csrReadD & ~(funct3D[1] & csrZeroSrcD); // No set/clear of zeros

  assign fenceID           = fenceXD & (funct3D == f3FenceI);
  assign invalidateICacheD = fenceID;
  assign flushDCacheD      = fenceID; // Write back D$ before I$ refill

  assign sfenceVmaD = privilegedD & (funct7D == f7SFenceVma);
  assign fenceD     = fenceXD | sfenceVmaD;

endmodule

// File: rtl/controller.sv
/* Pipeline controller top */
`timescale 1ns/100ps

module controller import rvIsaPkg::*, ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  // Decode
  input  logic       stallD, flushD,
  input  instrT      instrD,
  output immSrcT     immSrcD,
  output logic       illegalBaseInstrD,
  output logic       branchD, jumpD,
  output logic       instrValidD,
  output logic       storeStallD,       // Load/store right behind a store
  // Execute
  input  logic       stallE, flushE,
  input  logic [1:0] flagsE,            // {eq, lt}
  output logic       pcSrcE,
  output aluControlT aluControlE,
  output logic       aluSrcAE, aluSrcBE,
  output logic       aluResultSrcE,
  output logic       memReadE, csrReadE,
  output funct3T     funct3E,
  output logic       intDivE, mduE,
  output logic       jumpE, branchE,
  output logic       branchSignedE,
  output logic       instrValidE,
  // Memory
  input  logic       stallM, flushM,
  output memRwT      memRwM,
  output logic       csrReadM, csrWriteM, privilegedM,
  output funct3T     funct3M,
  output logic       regWriteM,
  output logic       invalidateICacheM, flushDCacheM,
  output logic       instrValidM,
  output logic       csrWriteFenceM,
  // Writeback
  input  logic       stallW, flushW,
  output logic       regWriteW, intDivW,
  output resultSrcT  resultSrcW
);

  opcodeT     opD;
  funct3T     funct3D;
  funct7T     funct7D;
  regAdrT     rs1D;
  logic       regWriteD, aluSrcAD, aluSrcBD, aluOpD, aluResultSrcD; // Main decoder outputs
  logic       csrReadD, privilegedD, fenceXD, mduD;
  resultSrcT  resultSrcD;
  memRwT      memRwD;
  aluControlT aluControlD;
  logic       csrWriteD, fenceD, invalidateICacheD, flushDCacheD; // ALU decoder outputs
  logic       regWriteE, csrWriteE, privilegedE, fenceE;            // Execute to Memory
  logic       invalidateICacheE, flushDCacheE;
  resultSrcT  resultSrcE;
  memRwT      memRwE;
  logic       memWriteE; // Store in Execute

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign opD     = instrD[6:0];
  assign funct3D = instrD[14:12];
  assign funct7D = instrD[31:25];
  assign rs1D    = instrD[19:15];

  mainDecoder mainDec (.opD, .funct3D, .funct7D, .regWriteD, .immSrcD, .aluSrcAD, .aluSrcBD,
    .memRwD, .resultSrcD, .branchD, .aluOpD, .jumpD, .aluResultSrcD, .csrReadD, .privilegedD,
    .fenceXD, .mduD, .illegalD(illegalBaseInstrD));

  aluDecoder aluDec (.opD, .funct3D, .funct7D, .rs1D, .aluOpD, .csrReadD, .privilegedD,
    .fenceXD, .aluControlD, .csrWriteD, .fenceD, .invalidateICacheD, .flushDCacheD);

  // Valid once out of reset or flush
  always_ff @(posedge clk) begin
    if (reset | flushD) instrValidD <= 1'b0;
    else if (~stallD) instrValidD <= 1'b1;
  end

  // D$ cannot take a load or store right after a store
  assign memWriteE   = memRwE[0];
  assign storeStallD = memWriteE & (memRwD[1] | memRwD[0]);

  //////////////////////////////
  // Execute, Memory, Writeback
  //////////////////////////////

  executeCtrl exeCtrl (.clk, .reset, .stallE, .flushE, .flagsE, .regWriteD, .resultSrcD,
    .memRwD, .jumpD, .branchD, .aluControlD, .aluSrcAD, .aluSrcBD, .aluResultSrcD, .csrReadD,
    .csrWriteD, .privilegedD, .funct3D, .mduD, .invalidateICacheD, .flushDCacheD, .fenceD,
    .instrValidD, .pcSrcE, .aluControlE, .aluSrcAE, .aluSrcBE, .aluResultSrcE, .memReadE,
    .csrReadE, .funct3E, .intDivE, .mduE, .jumpE, .branchE, .branchSignedE, .instrValidE,
    .regWriteE, .resultSrcE, .memRwE, .csrWriteE, .privilegedE, .invalidateICacheE,
    .flushDCacheE, .fenceE);

  memWbCtrl memWb (.clk, .reset, .stallM, .flushM, .stallW, .flushW, .regWriteE, .resultSrcE,
    .memRwE, .csrReadE, .csrWriteE, .privilegedE, .funct3E, .invalidateICacheE, .flushDCacheE,
    .fenceE, .instrValidE, .intDivE, .memRwM, .csrReadM, .csrWriteM, .privilegedM, .funct3M,
    .regWriteM, .invalidateICacheM, .flushDCacheM, .instrValidM, .csrWriteFenceM, .regWriteW,
    .resultSrcW, .intDivW);

endmodule

// File: rtl/ctrlPkg.sv
/* Pipeline control types */

package ctrlPkg;

  //////////////////////////////
  // Immediate and result select
  //////////////////////////////

  typedef enum logic [2:0] {
    immI = 3'b000, // Loads, ALU immediates, jalr
    immS = 3'b001, // Stores
    immB = 3'b010, // Branch offsets
    immJ = 3'b011, // jal offset
    immU = 3'b100  // lui, auipc
  } immSrcT;

  typedef enum logic [2:0] {
    resAlu = 3'b000, // ALU or IEU result
    resMem = 3'b001, // Load data
    resCsr = 3'b010, // CSR read data
    resMdu = 3'b011  // Multiply/divide unit
  } resultSrcT;

  //////////////////////////////
  // Memory access and ALU
  //////////////////////////////

  typedef logic [1:0] memRwT;      // Bit 1 read, bit 0 write
  typedef logic [1:0] aluControlT; // {subArith, aluOp}

  localparam memRwT memNone  = 2'b00;
  localparam memRwT memRead  = 2'b10;
  localparam memRwT memWrite = 2'b01;

  // Main decoder word, without the illegal flag and fenceX
  localparam int ctrlWidth = 18;

endpackage

// File: rtl/executeCtrl.sv
/* Execute stage control */
`timescale 1ns/100ps

module executeCtrl import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       stallE, flushE,       // From hazard unit
  input  logic [1:0] flagsE,               // Comparator {eq, lt}
  // Decode stage
  input  logic       regWriteD,
  input  resultSrcT  resultSrcD,
  input  memRwT      memRwD,
  input  logic       jumpD, branchD,
  input  aluControlT aluControlD,
  input  logic       aluSrcAD, aluSrcBD,
  input  logic       aluResultSrcD,
  input  logic       csrReadD, csrWriteD,
  input  logic       privilegedD,
  input  logic [2:0] funct3D,
  input  logic       mduD,
  input  logic       invalidateICacheD, flushDCacheD,
  input  logic       fenceD,
  input  logic       instrValidD,
  // Execute stage, datapath and hazard unit
  output logic       pcSrcE,               // Redirect fetch
  output aluControlT aluControlE,
  output logic       aluSrcAE, aluSrcBE,
  output logic       aluResultSrcE,
  output logic       memReadE,             // Load in Execute
  output logic       csrReadE,
  output logic [2:0] funct3E,
  output logic       intDivE,              // div, divu, rem, remu
  output logic       mduE,
  output logic       jumpE, branchE,
  output logic       branchSignedE,        // Signed compare
  output logic       instrValidE,
  // Execute stage, on to Memory
  output logic       regWriteE,
  output resultSrcT  resultSrcE,
  output memRwT      memRwE,
  output logic       csrWriteE,
  output logic       privilegedE,
  output logic       invalidateICacheE, flushDCacheE,
  output logic       fenceE
);

  logic eqE, ltE;
  logic branchFlagE;  // eq or lt per funct3
  logic branchTakenE;

  //////////////////////////////
  // Execute register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset | flushE) begin
      {regWriteE, memRwE, jumpE, branchE, aluControlE, aluSrcAE, aluSrcBE} <= '0;
      {aluResultSrcE, csrReadE, csrWriteE, privilegedE, funct3E, mduE} <= '0;
      {invalidateICacheE, flushDCacheE, fenceE, instrValidE} <= '0;
      resultSrcE <= resAlu; // Bubble
    end else if (~stallE) begin
      {regWriteE, memRwE, jumpE, branchE, aluControlE, aluSrcAE, aluSrcBE} <=
        {regWriteD, memRwD, jumpD, branchD, aluControlD, aluSrcAD, aluSrcBD};
      {aluResultSrcE, csrReadE, csrWriteE, privilegedE, funct3E, mduE} <=
        {aluResultSrcD, csrReadD, csrWriteD, privilegedD, funct3D, mduD};
      {invalidateICacheE, flushDCacheE, fenceE, instrValidE} <=
        {invalidateICacheD, flushDCacheD, fenceD, instrValidD};
      resultSrcE <= resultSrcD;
    end
  end

  //////////////////////////////
  // Branch resolution
  //////////////////////////////

  assign {eqE, ltE}    = flagsE;
  assign branchFlagE   = funct3E[2] ? ltE : eqE;       // blt/bge family uses lt
  assign branchTakenE  = branchFlagE ^ funct3E[0];     // bne, bge, bgeu invert
  assign pcSrcE        = jumpE | (branchE & branchTakenE);
  assign branchSignedE = ~(funct3E[2:1] == 2'b11);     // bltu, bgeu unsigned

  assign memReadE = memRwE[1];
  assign intDivE  = mduE & funct3E[2]; // Upper half of M funct3 is divide

endmodule

// File: rtl/mainDecoder.sv
/* Main opcode decoder */
`timescale 1ns/100ps

module mainDecoder import rvIsaPkg::*, ctrlPkg::*; (
  input  opcodeT    opD,           // Opcode field
  input  funct3T    funct3D,       // Splits privileged from CSR
  input  funct7T    funct7D,       // Splits R-type from mul/div
  output logic      regWriteD,     // Writes rd
  output immSrcT    immSrcD,       // Immediate format
  output logic      aluSrcAD,      // PC as operand A
  output logic      aluSrcBD,      // Immediate as operand B
  output memRwT     memRwD,        // Load / store
  output resultSrcT resultSrcD,    // Writeback source
  output logic      branchD,
  output logic      aluOpD,        // Operation from funct3, else add
  output logic      jumpD,         // jal, jalr
  output logic      aluResultSrcD, // Alternate ALU result (lui, link)
  output logic      csrReadD,
  output logic      privilegedD,   // ecall, ebreak, xret, wfi, sfence.vma
  output logic      fenceXD,       // fence or fence.i
  output logic      mduD,          // Multiply/divide
  output logic      illegalD       // Unsupported encoding
);

  logic [ctrlWidth-1:0] controls; // Packed Decode control word

  //////////////////////////////
  // Opcode table
  //////////////////////////////

  always_comb begin
    controls = '0;
    illegalD = 1'b0;
    case (opD)
      // regWrite immSrc srcAB memRw resultSrc {br aluOp jmp aluRes} {csr priv mdu}
      opLoad:   controls = {1'b1, immI, 2'b01, memRead, resMem, 4'b0000, 3'b000};
      opFence:  controls = '0; // Legal, flagged through fenceXD only
      opImm:    controls = {1'b1, immI, 2'b01, memNone, resAlu, 4'b0100, 3'b000};
      opAuipc:  controls = {1'b1, immU, 2'b11, memNone, resAlu, 4'b0000, 3'b000}; // PC + imm
      opStore:  controls = {1'b0, immS, 2'b01, memWrite, resAlu, 4'b0000, 3'b000};
      opReg: begin
        if (funct7D == f7Base || funct7D == f7Alt) begin
          controls = {1'b1, immI, 2'b00, memNone, resAlu, 4'b0100, 3'b000}; // R-type
        end else if (funct7D == f7MulDiv) begin
          controls = {1'b1, immI, 2'b00, memNone, resMdu, 4'b0000, 3'b001}; // mul/div
        end else begin
          illegalD = 1'b1; // Unknown funct7
        end
      end
      opLui:    controls = {1'b1, immU, 2'b01, memNone, resAlu, 4'b0001, 3'b000};
      opBranch: controls = {1'b0, immB, 2'b11, memNone, resAlu, 4'b1000, 3'b000}; // Target PC + imm
      opJalr:   controls = {1'b1, immI, 2'b01, memNone, resAlu, 4'b0011, 3'b000};
      opJal:    controls = {1'b1, immJ, 2'b11, memNone, resAlu, 4'b0011, 3'b000};
      opSystem: begin
        if (funct3D == f3Priv) begin
          controls = {1'b0, immI, 2'b00, memNone, resAlu, 4'b0000, 3'b010}; // Privileged unit
        end else begin
          controls = {1'b1, immI, 2'b00, memNone, resCsr, 4'b0000, 3'b100}; // csrr*
        end
      end
      default:  illegalD = 1'b1; // Unknown opcode, all zeros too
    endcase
  end

  //////////////////////////////
  // Unpack word
  //////////////////////////////

  assign regWriteD     = controls[17];
  assign immSrcD       = immSrcT'(controls[16:14]);
  assign aluSrcAD      = controls[13];
  assign aluSrcBD      = controls[12];
  assign memRwD        = controls[11:10];
  assign resultSrcD    = resultSrcT'(controls[9:7]);
  assign branchD       = controls[6];
  assign aluOpD        = controls[5];
  assign jumpD         = controls[4];
  assign aluResultSrcD = controls[3];
  assign csrReadD      = controls[2];
  assign privilegedD   = controls[1];
  assign mduD          = controls[0];

  // Fence class needs only the opcode
  assign fenceXD = (opD == opFence);

endmodule

// File: rtl/memWbCtrl.sv
/* Memory and Writeback control */
`timescale 1ns/100ps

module memWbCtrl import ctrlPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       stallM, flushM,
  input  logic       stallW, flushW,
  // Execute stage
  input  logic       regWriteE,
  input  resultSrcT  resultSrcE,
  input  memRwT      memRwE,
  input  logic       csrReadE, csrWriteE,
  input  logic       privilegedE,
  input  logic [2:0] funct3E,
  input  logic       invalidateICacheE, flushDCacheE,
  input  logic       fenceE,
  input  logic       instrValidE,
  input  logic       intDivE,
  // Memory stage
  output memRwT      memRwM,            // To LSU
  output logic       csrReadM, csrWriteM,
  output logic       privilegedM,
  output logic [2:0] funct3M,           // Access size and sign
  output logic       regWriteM,         // For forwarding
  output logic       invalidateICacheM, flushDCacheM,
  output logic       instrValidM,
  output logic       csrWriteFenceM,    // Flush younger stages
  // Writeback stage
  output logic       regWriteW,
  output resultSrcT  resultSrcW,
  output logic       intDivW
);

  resultSrcT resultSrcM;
  logic      fenceM;
  logic      intDivM;

  //////////////////////////////
  // Memory register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset | flushM) begin
      {regWriteM, memRwM, csrReadM, csrWriteM, privilegedM, funct3M} <= '0;
      {invalidateICacheM, flushDCacheM, fenceM, instrValidM, intDivM} <= '0;
      resultSrcM <= resAlu;
    end else if (~stallM) begin
      {regWriteM, memRwM, csrReadM, csrWriteM, privilegedM, funct3M} <=
        {regWriteE, memRwE, csrReadE, csrWriteE, privilegedE, funct3E};
      {invalidateICacheM, flushDCacheM, fenceM, instrValidM, intDivM} <=
        {invalidateICacheE, flushDCacheE, fenceE, instrValidE, intDivE};
      resultSrcM <= resultSrcE;
    end
  end

  // CSR write or fence changes state younger instructions may have used
  assign csrWriteFenceM = csrWriteM | fenceM;

  //////////////////////////////
  // Writeback register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset | flushW) begin
      {regWriteW, intDivW} <= '0;
      resultSrcW <= resAlu;
    end else if (~stallW) begin
      {regWriteW, intDivW} <= {regWriteM, intDivM};
      resultSrcW <= resultSrcM;
    end
  end

endmodule

// File: rtl/rvIsaPkg.sv
/* RV32 instruction encoding */

package rvIsaPkg;

  //////////////////////////////
  // Field types
  //////////////////////////////

  typedef logic [31:0] instrT;  // Full 32-bit instruction
  typedef logic [6:0]  opcodeT; // instr[6:0]
  typedef logic [2:0]  funct3T; // instr[14:12]
  typedef logic [6:0]  funct7T; // instr[31:25]
  typedef logic [4:0]  regAdrT; // rs1, rs2 or rd

  //////////////////////////////
  // Opcodes by class
  //////////////////////////////

  localparam opcodeT opLoad   = 7'b0000011; // lb lh lw lbu lhu
  localparam opcodeT opFence  = 7'b0001111; // fence, fence.i
  localparam opcodeT opImm    = 7'b0010011; // ALU with immediate
  localparam opcodeT opAuipc  = 7'b0010111;
  localparam opcodeT opStore  = 7'b0100011; // sb sh sw
  localparam opcodeT opReg    = 7'b0110011; // Register ALU and mul/div
  localparam opcodeT opLui    = 7'b0110111;
  localparam opcodeT opBranch = 7'b1100011;
  localparam opcodeT opJalr   = 7'b1100111;
  localparam opcodeT opJal    = 7'b1101111;
  localparam opcodeT opSystem = 7'b1110011; // CSR access and privileged

  //////////////////////////////
  // funct7 and funct3 codes
  //////////////////////////////

  localparam funct7T f7Base      = 7'b0000000; // add, srl and the rest
  localparam funct7T f7Alt       = 7'b0100000; // sub, sra
  localparam funct7T f7MulDiv    = 7'b0000001; // M extension
  localparam funct7T f7SFenceVma = 7'b0001001; // Under the privileged opcode

  localparam funct3T f3Priv   = 3'b000; // System with no CSR access
  localparam funct3T f3FenceI = 3'b001; // Zifencei
  localparam funct3T f3AddSub = 3'b000;
  localparam funct3T f3Slt    = 3'b010;
  localparam funct3T f3Sltu   = 3'b011;
  localparam funct3T f3Shr    = 3'b101; // srl or sra

endpackage

// File: run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module controllerTb \
  --Mdir obj_dir -o controllerSim
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/controllerSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
echo "Simulation finished without failure"
exit 0

// File: sim/clockGen.sv
/* Testbench clock and reset */
`timescale 1ns/100ps

module clockGen (
  output logic clk,
  output logic reset
);

  localparam int halfPeriod = 10; // 20 ns clock

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (2) @(posedge clk); // Two reset cycles
    #2 reset = 1'b0;
  end

  always #halfPeriod clk = ~clk;

endmodule

// File: sim/refDecode.svh
/* Reference control values */
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

// Bits: 22 regWrite, 21:19 immSrc, 18 srcA, 17 srcB, 16:15 memRw, 14:12 resultSrc,
// 11 branch, 10 aluOp, 9 jump, 8 aluResSrc, 7 csrRead, 6 priv, 5 mdu, 4 illegal,
// 3 subArith, 2 csrWrite, 1 fence, 0 fence.i
function automatic logic [22:0] refCtrl(input instrT instr);
  opcodeT      op;
  funct3T      f3;
  funct7T      f7;
  logic [22:0] w;
  op = instr[6:0];
  f3 = instr[14:12];
  f7 = instr[31:25];
  w  = '0;
  case (op)
    opLoad:   begin w[22] = 1'b1; w[17] = 1'b1; w[16:15] = 2'b10; w[14:12] = resMem; end
    opFence:  begin w[1] = 1'b1; w[0] = (f3 == f3FenceI); end
    opImm:    begin w[22] = 1'b1; w[17] = 1'b1; w[10] = 1'b1; end
    opAuipc:  begin w[22] = 1'b1; w[21:19] = immU; w[18] = 1'b1; w[17] = 1'b1; end
    opStore:  begin w[21:19] = immS; w[17] = 1'b1; w[16:15] = 2'b01; end
    opReg: begin
      if (f7 == f7Base || f7 == f7Alt) begin
        w[22] = 1'b1; w[10] = 1'b1;
      end else if (f7 == f7MulDiv) begin
        w[22] = 1'b1; w[14:12] = resMdu; w[5] = 1'b1;
      end else w[4] = 1'b1; // Bad funct7
    end
    opLui:    begin w[22] = 1'b1; w[21:19] = immU; w[17] = 1'b1; w[8] = 1'b1; end
    opBranch: begin w[21:19] = immB; w[18] = 1'b1; w[17] = 1'b1; w[11] = 1'b1; end
    opJalr:   begin w[22] = 1'b1; w[17] = 1'b1; w[9] = 1'b1; w[8] = 1'b1; end
    opJal:    begin w[22] = 1'b1; w[21:19] = immJ; w[18:17] = 2'b11; w[9:8] = 2'b11; end
    opSystem: begin
      if (f3 == f3Priv) begin
        w[6] = 1'b1; w[1] = (f7 == f7SFenceVma);
      end else begin
        w[22] = 1'b1; w[14:12] = resCsr; w[7] = 1'b1;
        w[2]  = !(f3[1] && instr[19:15] == 5'd0); // Set/clear with zero source
      end
    end
    default:  w[4] = 1'b1;
  endcase
  if (w[10]) // Inverted operand B ops
    w[3] = (f3 == 3'd0 && f7[5] && op[5]) || (f3 == 3'd5 && f7[5]) || f3 == 3'd2 || f3 == 3'd3;
  return w;
endfunction

`endif

// File: sim/controllerTb.sv
/* Controller testbench */
`timescale 1ns/100ps

module controllerTb import rvIsaPkg::*, ctrlPkg::*; ();

  `include "refDecode.svh"

  localparam int numDirected = 54;
  localparam int numRandom   = 400;
  localparam int cycleLimit  = 4 * (numDirected + numRandom) + 50;
  localparam logic [31:0] lcgMul = 32'd1664525;
  localparam logic [31:0] lcgInc = 32'd1013904223;
  localparam logic [31:0] seed   = 32'd64;

  logic clk, reset;
  logic stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW;
  instrT instrD;
  logic [1:0] flagsE;
  immSrcT immSrcD;
  logic illegalBaseInstrD, branchD, jumpD, instrValidD, storeStallD;
  logic pcSrcE, aluSrcAE, aluSrcBE, aluResultSrcE, memReadE, csrReadE;
  aluControlT aluControlE;
  funct3T funct3E, funct3M;
  logic intDivE, mduE, jumpE, branchE, branchSignedE, instrValidE;
  memRwT memRwM;
  logic csrReadM, csrWriteM, privilegedM, regWriteM, invalidateICacheM, flushDCacheM;
  logic instrValidM, csrWriteFenceM, regWriteW, intDivW;
  resultSrcT resultSrcW;

  // Shadow pipeline
  instrT instrE, instrM, instrW;
  logic  vD, vE, vM, liveE, liveM, liveW;
  logic  checksOn = 1'b0;
  int    cycleCount = 0;
  logic [31:0] lcgState;
  instrT dirQ[$];
  opcodeT opTable[11];

  clockGen clkGen (.clk, .reset);
  controller controller_i (.*);

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * lcgMul + lcgInc;
  endfunction

  function automatic instrT mkInstr(input funct7T f7, input regAdrT rs1, input funct3T f3,
                                    input opcodeT op);
    return {f7, 5'd2, rs1, f3, 5'd3, op};
  endfunction

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // sf = {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW}
  task automatic applyCycle(input instrT instr, input logic [1:0] flags, input logic [7:0] sf);
    @(posedge clk);
    #2;
    instrD = instr;
    flagsE = flags;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = sf;
  endtask

  //////////////////////////////
  // Shadow pipeline and timeout
  //////////////////////////////

  always @(posedge clk) begin
    checksOn <= 1'b1;
    cycleCount <= cycleCount + 1;
    if (reset | flushD) vD <= 1'b0;
    else if (!stallD) vD <= 1'b1;
    if (reset | flushE) {liveE, vE, instrE} <= '0;
    else if (!stallE) {liveE, vE, instrE} <= {1'b1, vD, instrD}; // Decode bits load always
    if (reset | flushM) {liveM, vM, instrM} <= '0;
    else if (!stallM) {liveM, vM, instrM} <= {liveE, vE, instrE};
    if (reset | flushW) {liveW, instrW} <= '0;
    else if (!stallW) {liveW, instrW} <= {liveM, instrM};
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run went past %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Checks at falling edge
  //////////////////////////////

  always @(negedge clk) begin : checkOutputs
    logic [22:0] cD, cE, cM, cW;
    funct3T      f3E, f3M;
    logic        taken;
    if (checksOn) begin
      cD  = refCtrl(instrD);
      cE  = liveE ? refCtrl(instrE) : '0; // Bubble reads zero
      cM  = liveM ? refCtrl(instrM) : '0;
      cW  = liveW ? refCtrl(instrW) : '0;
      f3E = liveE ? instrE[14:12] : 3'd0;
      f3M = liveM ? instrM[14:12] : 3'd0;
      taken = (f3E[2] ? flagsE[0] : flagsE[1]) ^ f3E[0]; // lt or eq flag inverted by bit 0
      // Decode
      checkVal("immSrcD", 32'(immSrcD), 32'(cD[21:19]));
      checkVal("illegalBaseInstrD", 32'(illegalBaseInstrD), 32'(cD[4]));
      checkVal("branchD", 32'(branchD), 32'(cD[11]));
      checkVal("jumpD", 32'(jumpD), 32'(cD[9]));
      checkVal("instrValidD", 32'(instrValidD), 32'(vD));
      checkVal("storeStallD", 32'(storeStallD), 32'(cE[15] & (cD[16] | cD[15])));
      // Execute
      checkVal("pcSrcE", 32'(pcSrcE), 32'(cE[9] | (cE[11] & taken)));
      checkVal("aluControlE", 32'(aluControlE), 32'({cE[3], cE[10]}));
      checkVal("aluSrcAE", 32'(aluSrcAE), 32'(cE[18]));
      checkVal("aluSrcBE", 32'(aluSrcBE), 32'(cE[17]));
      checkVal("aluResultSrcE", 32'(aluResultSrcE), 32'(cE[8]));
      checkVal("memReadE", 32'(memReadE), 32'(cE[16]));
      checkVal("csrReadE", 32'(csrReadE), 32'(cE[7]));
      checkVal("funct3E", 32'(funct3E), 32'(f3E));
      checkVal("intDivE", 32'(intDivE), 32'(cE[5] & f3E[2]));
      checkVal("mduE", 32'(mduE), 32'(cE[5]));
      checkVal("jumpE", 32'(jumpE), 32'(cE[9]));
      checkVal("branchE", 32'(branchE), 32'(cE[11]));
      checkVal("branchSignedE", 32'(branchSignedE), 32'(f3E[2:1] != 2'b11));
      checkVal("instrValidE", 32'(instrValidE), 32'(vE));
      // Memory
      checkVal("memRwM", 32'(memRwM), 32'(cM[16:15]));
      checkVal("csrReadM", 32'(csrReadM), 32'(cM[7]));
      checkVal("csrWriteM", 32'(csrWriteM), 32'(cM[2]));
      checkVal("privilegedM", 32'(privilegedM), 32'(cM[6]));
      checkVal("funct3M", 32'(funct3M), 32'(f3M));
      checkVal("regWriteM", 32'(regWriteM), 32'(cM[22]));
      checkVal("invalidateICacheM", 32'(invalidateICacheM), 32'(cM[0]));
      checkVal("flushDCacheM", 32'(flushDCacheM), 32'(cM[0]));
      checkVal("instrValidM", 32'(instrValidM), 32'(vM));
      checkVal("csrWriteFenceM", 32'(csrWriteFenceM), 32'(cM[2] | cM[1]));
      // Writeback
      checkVal("regWriteW", 32'(regWriteW), 32'(cW[22]));
      checkVal("resultSrcW", 32'(resultSrcW), 32'(cW[14:12]));
      checkVal("intDivW", 32'(intDivW), 32'(cW[5] & instrW[14]));
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    logic [31:0] r1, r2, r3;
    instrT       instr;
    logic [7:0]  sf;
    int          idx;
    {stallD, flushD, stallE, flushE, stallM, flushM, stallW, flushW} = '0;
    instrD = '0;
    flagsE = 2'b00;
    lcgState = seed;
    opTable = '{opLoad, opFence, opImm, opAuipc, opStore, opReg, opLui, opBranch,
                opJalr, opJal, opSystem};
    // ALU ops, mul/div, bad funct7
    dirQ.push_back(mkInstr(f7Base, 5'd1, 3'd0, opReg));
    dirQ.push_back(mkInstr(f7Alt, 5'd1, 3'd0, opReg));     // sub
    dirQ.push_back(mkInstr(f7Alt, 5'd1, 3'd5, opReg));     // sra
    dirQ.push_back(mkInstr(f7Base, 5'd1, 3'd2, opReg));    // slt
    dirQ.push_back(mkInstr(f7Base, 5'd1, 3'd3, opReg));    // sltu
    dirQ.push_back(mkInstr(f7Alt, 5'd1, 3'd0, opImm));     // addi never subtracts
    dirQ.push_back(mkInstr(f7Alt, 5'd1, 3'd5, opImm));     // srai
    dirQ.push_back(mkInstr(f7MulDiv, 5'd1, 3'd0, opReg));  // mul
    dirQ.push_back(mkInstr(f7MulDiv, 5'd1, 3'd4, opReg));  // div
    dirQ.push_back(mkInstr(7'b0000010, 5'd1, 3'd0, opReg));
    // Loads and stores back to back
    dirQ.push_back(mkInstr(7'd0, 5'd1, 3'd2, opLoad));
    dirQ.push_back(mkInstr(7'd0, 5'd1, 3'd2, opStore));
    dirQ.push_back(mkInstr(7'd0, 5'd1, 3'd2, opLoad));     // Store stall
    dirQ.push_back(mkInstr(7'd0, 5'd1, 3'd2, opStore));
    dirQ.push_back(mkInstr(7'd0, 5'd1, 3'd2, opStore));    // Store stall
    dirQ.push_back(mkInstr(7'd5, 5'd1, 3'd0, opLui));
    dirQ.push_back(mkInstr(7'd5, 5'd1, 3'd0, opAuipc));
    dirQ.push_back(mkInstr(7'd5, 5'd1, 3'd0, opJal));
    dirQ.push_back(mkInstr(7'd5, 5'd1, 3'd0, opJalr));
    // CSR with zero and nonzero sources
    dirQ.push_back(mkInstr(7'h18, 5'd0, 3'd2, opSystem));  // csrrs x0
    dirQ.push_back(mkInstr(7'h18, 5'd0, 3'd3, opSystem));  // csrrc x0
    dirQ.push_back(mkInstr(7'h18, 5'd0, 3'd6, opSystem));  // csrrsi 0
    dirQ.push_back(mkInstr(7'h18, 5'd0, 3'd1, opSystem));  // csrrw x0 still writes
    dirQ.push_back(mkInstr(7'h18, 5'd5, 3'd2, opSystem));
    dirQ.push_back(32'h00000073);                          // ecall
    dirQ.push_back(mkInstr(f7SFenceVma, 5'd0, 3'd0, opSystem));
    dirQ.push_back(mkInstr(7'd0, 5'd0, 3'd0, opFence));
    dirQ.push_back(mkInstr(7'd0, 5'd0, f3FenceI, opFence));
    dirQ.push_back(32'h00000000);
    dirQ.push_back(32'hFFFFFFFF);
    // Each branch kind four times in a row
    for (int i = 0; i < 6; i++) begin
      idx = (i < 2) ? i : i + 2; // 0 1 4 5 6 7
      repeat (4) dirQ.push_back(mkInstr(7'd0, 5'd1, 3'(idx), opBranch));
    end
    wait (!reset);
    foreach (dirQ[i]) applyCycle(dirQ[i], 2'(i), 8'h00); // Flags cycle with index
    // Random phase
    repeat (numRandom) begin
      lcgState = lcgNext(lcgState);
      r1 = lcgState;
      lcgState = lcgNext(lcgState);
      r2 = lcgState;
      lcgState = lcgNext(lcgState);
      r3 = lcgState;
      instr = r1;
      idx = r2[31:28] % 12;
      if (idx != 11) instr[6:0] = opTable[idx]; // Else keep the random opcode
      if (instr[6:0] == opReg && r2[27:26] != 2'b11)
        instr[31:25] = (r2[27:26] == 2'b00) ? f7Base : (r2[26] ? f7Alt : f7MulDiv);
      if (r2[25]) instr[19:15] = 5'd0;                     // Zero CSR source
      for (int k = 0; k < 8; k++) sf[k] = (r3[3*k+8 +: 3] == 3'd0); // About one in eight
      applyCycle(instr, r2[1:0], sf);
    end
    repeat (5) applyCycle(mkInstr(7'd0, 5'd0, 3'd0, opImm), 2'b00, 8'h00); // Drain
    @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
